/* logic/mem_map_pkg.sv */
package mem_map_pkg;

    // Address region of a CPU data access
    typedef enum logic [2:0] {
        REGION_DRAM,
        REGION_CLINT,
        REGION_PLIC,
        REGION_FB,
        REGION_NONE
    } region_e;

    // Device nibbles, address bits 31:28
    localparam logic [3:0] DEV_DRAM_LO = 4'h0;
    localparam logic [3:0] DEV_DRAM_HI = 4'h8;
    localparam logic [3:0] DEV_VIRTIO  = 4'h4;
    localparam logic [3:0] DEV_PLIC    = 4'h6;
    localparam logic [3:0] DEV_CLINT   = 4'h7;

    // Framebuffer slot inside the VirtIO window, bits 27:24
    localparam logic [3:0] VIRT_FB = 4'h5;

    // 128 MiB DRAM offset
    localparam logic [31:0] OFFSET_MASK = 32'h07ff_ffff;

    // Host command word, in an otherwise unused VirtIO slot
    localparam logic [31:0] TOHOST_ADDR = 32'h4000_1000;

    // Commands live in bits 31:16 of the tohost word
    typedef enum logic [15:0] {
        CMD_POWER_OFF  = 16'h0001,
        CMD_PRINT_CHAR = 16'h0101
    } host_cmd_e;

endpackage

/* logic/access_pkg.sv */
package access_pkg;

    // DRAM line width in bits
    localparam int LINE_W = 128;

    // RISC-V funct3 of loads and stores
    // Bit 2 marks unsigned, bits 1:0 give the size
    typedef enum logic [2:0] {
        W_LB  = 3'b000,
        W_LH  = 3'b001,
        W_LW  = 3'b010,
        W_LBU = 3'b100,
        W_LHU = 3'b101
    } width_e;

    // Stores share the funct3 codes of the signed loads
    localparam width_e W_SB = W_LB;
    localparam width_e W_SH = W_LH;
    localparam width_e W_SW = W_LW;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        width_e      width;
        logic        read;
        logic        write;
    } cpu_req_t;

    typedef struct packed {
        logic        rd_en;
        logic        wr_en;
        logic [31:0] addr;
        logic [31:0] wdata;
        width_e      width;
    } dram_req_t;

    typedef struct packed {
        logic        plic_we;
        logic        plic_re;
        logic        clint_we;
        logic        fb_we;
        logic [31:0] wdata;
    } mmio_strobe_t;

endpackage

/* logic/region_decoder.sv */
module region_decoder (
    input  access_pkg::cpu_req_t     cpu_req,
    input  logic                     dram_busy,
    output access_pkg::dram_req_t    dram_req,
    output access_pkg::mmio_strobe_t mmio,
    output mem_map_pkg::region_e     region,
    output logic [27:0]              offset
);
    import mem_map_pkg::*;

    logic [3:0]  dev;
    logic [3:0]  virt;
    logic [31:0] masked_addr;
    logic        dram_free;

    assign dev  = cpu_req.addr[31:28];
    assign virt = cpu_req.addr[27:24];

    // Both DRAM windows alias onto the same 128 MiB
    assign masked_addr = cpu_req.addr & OFFSET_MASK;
    assign offset      = masked_addr[27:0];

    always_comb begin
        case (dev)
            DEV_DRAM_LO,
            DEV_DRAM_HI: region = REGION_DRAM;
            DEV_CLINT:   region = REGION_CLINT;
            DEV_PLIC:    region = REGION_PLIC;
            DEV_VIRTIO: begin
                // Only the framebuffer slot is still populated
                if (virt == VIRT_FB) begin
                    region = REGION_FB;
                end else begin
                    region = REGION_NONE;
                end
            end
            default:     region = REGION_NONE;
        endcase
    end

    // DRAM is held off while it is busy
    assign dram_free = (region == REGION_DRAM) && !dram_busy;

    // TOHOST_ADDR sits in the VirtIO window, so it never reaches DRAM
    assign dram_req.rd_en = dram_free && cpu_req.read;
    assign dram_req.wr_en = dram_free && cpu_req.write;
    assign dram_req.addr  = masked_addr;
    assign dram_req.wdata = cpu_req.wdata;
    assign dram_req.width = cpu_req.width;

    // Device strobes go out regardless of DRAM busy
    assign mmio.plic_we  = (region == REGION_PLIC) && cpu_req.write;
    assign mmio.plic_re  = (region == REGION_PLIC) && cpu_req.read;
    assign mmio.clint_we = (region == REGION_CLINT) && cpu_req.write;
    assign mmio.fb_we    = (region == REGION_FB) && cpu_req.write;
    assign mmio.wdata    = cpu_req.wdata;

endmodule

/* logic/load_aligner.sv */
module load_aligner (
    input  logic                          CLK,
    input  logic                          reset,
    input  access_pkg::dram_req_t         dram_req,
    input  logic [access_pkg::LINE_W-1:0] dram_rdata,
    output logic [31:0]                   load_data
);
    import access_pkg::*;

    logic [3:0]        byte_off_q;
    width_e            width_q;
    logic [LINE_W-1:0] line_shifted;
    logic [31:0]       word;

    // Remember where in the line the pending load sits
    always_ff @(posedge CLK) begin
        if (reset) begin
            byte_off_q <= 4'h0;
            width_q    <= W_LW;
        end else if (dram_req.rd_en) begin
            byte_off_q <= dram_req.addr[3:0];
            width_q    <= dram_req.width;
        end
    end

    // Line arrives one cycle after the read enable
    assign line_shifted = dram_rdata >> {byte_off_q, 3'b000};
    assign word         = line_shifted[31:0];

    // Sign or zero extension by load type
    always_comb begin
        case (width_q)
            W_LB:    load_data = {{24{word[7]}}, word[7:0]};
            W_LBU:   load_data = {24'h0, word[7:0]};
            W_LH:    load_data = {{16{word[15]}}, word[15:0]};
            W_LHU:   load_data = {16'h0, word[15:0]};
            default: load_data = word;
        endcase
    end

endmodule

/* logic/read_return_mux.sv */
module read_return_mux (
    input  logic                 CLK,
    input  logic                 reset,
    input  mem_map_pkg::region_e region,
    input  logic [31:0]          load_data,
    input  logic [31:0]          plic_rdata,
    input  logic [31:0]          clint_rdata,
    input  logic [31:0]          fb_rdata,
    output logic [31:0]          rdata
);
    import mem_map_pkg::*;

    region_e region_q;

    // Region of last cycle's access, matching the one-cycle read latency
    always_ff @(posedge CLK) begin
        if (reset) begin
            region_q <= REGION_NONE;
        end else begin
            region_q <= region;
        end
    end

    always_comb begin
        case (region_q)
            REGION_DRAM:  rdata = load_data;
            REGION_CLINT: rdata = clint_rdata;
            REGION_PLIC:  rdata = plic_rdata;
            REGION_FB:    rdata = fb_rdata;
            // Dropped VirtIO slots and unmapped space read as zero
            default:      rdata = 32'h0;
        endcase
    end

endmodule

/* logic/host_command.sv */
module host_command (
    input  logic                 CLK,
    input  logic                 reset,
    input  access_pkg::cpu_req_t cpu_req,
    output logic                 uart_we,
    output logic [7:0]           uart_data,
    output logic                 finish
);
    import mem_map_pkg::*;

    logic [31:0] tohost_q;
    logic        tohost_wr;
    logic        print_pending;

    // Writes after power-off are ignored
    assign tohost_wr     = cpu_req.write && (cpu_req.addr == TOHOST_ADDR) && !finish;
    assign print_pending = (tohost_q[31:16] == CMD_PRINT_CHAR);

    always_ff @(posedge CLK) begin
        if (reset) begin
            tohost_q <= 32'h0;
            finish   <= 1'b0;
        end else if (tohost_wr) begin
            tohost_q <= cpu_req.wdata;
            if (cpu_req.wdata[31:16] == CMD_POWER_OFF) begin
                finish <= 1'b1;
            end
        end else if (print_pending) begin
            // Print command is consumed after one cycle
            tohost_q <= 32'h0;
        end
    end

    // Console strobe follows the register by one cycle
    always_ff @(posedge CLK) begin
        if (reset) begin
            uart_we <= 1'b0;
        end else begin
            uart_we <= print_pending;
        end
    end

    always_ff @(posedge CLK) begin
        if (print_pending) begin
            uart_data <= tohost_q[7:0];
        end
    end

endmodule

/* logic/mem_interconnect.sv */
module mem_interconnect (
    input  logic                          CLK,
    input  logic                          reset,
    input  access_pkg::cpu_req_t          cpu_req,
    input  logic                          dram_busy,
    input  logic [access_pkg::LINE_W-1:0] dram_rdata,
    input  logic [31:0]                   plic_rdata,
    input  logic [31:0]                   clint_rdata,
    input  logic [31:0]                   fb_rdata,
    output access_pkg::dram_req_t         dram_req,
    output access_pkg::mmio_strobe_t      mmio,
    output logic [27:0]                   offset,
    output logic [31:0]                   rdata,
    output logic                          proc_busy,
    output logic                          uart_we,
    output logic [7:0]                    uart_data,
    output logic                          finish
);
    import mem_map_pkg::*;

    region_e     region;
    logic [31:0] load_data;

    // CPU stalls only on DRAM
    assign proc_busy = dram_busy;

    region_decoder u_decoder (
        .cpu_req   (cpu_req),
        .dram_busy (dram_busy),
        .dram_req  (dram_req),
        .mmio      (mmio),
        .region    (region),
        .offset    (offset)
    );

    load_aligner u_aligner (
        .CLK        (CLK),
        .reset      (reset),
        .dram_req   (dram_req),
        .dram_rdata (dram_rdata),
        .load_data  (load_data)
    );

    read_return_mux u_return (
        .CLK         (CLK),
        .reset       (reset),
        .region      (region),
        .load_data   (load_data),
        .plic_rdata  (plic_rdata),
        .clint_rdata (clint_rdata),
        .fb_rdata    (fb_rdata),
        .rdata       (rdata)
    );

    host_command u_host (
        .CLK       (CLK),
        .reset     (reset),
        .cpu_req   (cpu_req),
        .uart_we   (uart_we),
        .uart_data (uart_data),
        .finish    (finish)
    );

endmodule

/* testbench/dram_model.sv */
module dram_model (
    input  logic                          CLK,
    input  logic                          reset,
    input  access_pkg::dram_req_t         dram_req,
    input  logic [7:0]                    busy_pattern,
    output logic                          dram_busy,
    output logic [access_pkg::LINE_W-1:0] dram_rdata
);
    timeunit 1ns;
    timeprecision 1ps;
    import access_pkg::*;

    // 256-byte window that higher offset bits alias onto
    logic [LINE_W-1:0] mem [0:15];
    logic [2:0]        phase;

    // Busy repeats every eight cycles
    assign dram_busy = busy_pattern[phase];

    always @(posedge CLK) begin
        if (reset) begin
            phase      <= 3'd0;
            dram_rdata <= '0;
            // Fill byte follows its address
            for (int i = 0; i < 16; i++) begin
                for (int j = 0; j < 16; j++) begin
                    mem[i][j * 8 +: 8] <= 8'(i * 16 + j) ^ 8'h5c;
                end
            end
        end else begin
            phase <= phase + 3'd1;
            if (dram_req.rd_en) begin
                dram_rdata <= mem[dram_req.addr[7:4]];
            end
            if (dram_req.wr_en) begin
                // Little-endian byte lanes of the store
                for (int b = 0; b < 4; b++) begin
                    if (b < (1 << dram_req.width[1:0])) begin
                        mem[dram_req.addr[7:4]][(dram_req.addr[3:0] + b) * 8 +: 8]
                            <= dram_req.wdata[b * 8 +: 8];
                    end
                end
            end
        end
    end

endmodule

/* testbench/tb_mem_interconnect.sv */
module tb_mem_interconnect;
    timeunit 1ns;
    timeprecision 1ps;
    import access_pkg::*;

    localparam int N_RAND = 300;
    localparam int N_BUSY = 40;
    localparam int N_MMIO = 32;
    localparam int N_ACCESS = N_RAND + N_BUSY + 2 * N_MMIO + 20;
    localparam logic [31:0] ADDR_MASK = 32'h07ff_ffff;
    localparam logic [31:0] TOHOST = 32'h4000_1000;

    logic              CLK;
    logic              reset;
    logic              dram_busy;
    logic              proc_busy;
    logic              uart_we;
    logic              finish;
    cpu_req_t          cpu_req;
    dram_req_t         dram_req;
    mmio_strobe_t      mmio;
    logic [LINE_W-1:0] dram_rdata;
    logic [31:0]       plic_rdata;
    logic [31:0]       clint_rdata;
    logic [31:0]       fb_rdata;
    logic [31:0]       rdata;
    logic [27:0]       offset;
    logic [7:0]        uart_data;
    logic [7:0]        busy_pattern;

    // Expectations of the access in flight and their delayed copies
    logic        acc_valid;
    logic        rd_pend;
    logic        rd_pend_q;
    logic        print_wr;
    logic        print_d1;
    logic        print_d2;
    logic        pwr_wr;
    logic        fin_exp;
    logic [31:0] exp_rdata;
    logic [31:0] exp_rdata_q;
    logic [7:0]  print_byte;
    logic [7:0]  byte_d1;
    logic [7:0]  byte_d2;
    logic [5:0]  exp_en;
    logic [5:0]  strobes;
    logic [7:0]  ref_mem [0:255];
    logic [31:0] seed;
    int          value_errors;
    int          protocol_errors;

    mem_interconnect dut0 (.*);
    dram_model u_dram (.*);

    assign strobes = {dram_req.rd_en, dram_req.wr_en, mmio.plic_we, mmio.plic_re,
                      mmio.clint_we, mmio.fb_we};

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Little-endian load from the reference bytes with the extension of the load type
    function automatic logic [31:0] expected_load(input logic [7:0] a, input width_e w);
        case (w)
            W_LB:    return {{24{ref_mem[a][7]}}, ref_mem[a]};
            W_LBU:   return {24'h0, ref_mem[a]};
            W_LH:    return {{16{ref_mem[a + 8'd1][7]}}, ref_mem[a + 8'd1], ref_mem[a]};
            W_LHU:   return {16'h0, ref_mem[a + 8'd1], ref_mem[a]};
            default: return {ref_mem[a + 8'd3], ref_mem[a + 8'd2], ref_mem[a + 8'd1], ref_mem[a]};
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        value_errors++;
        $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
    endtask

    // Called at a falling edge and returns at the falling edge after acceptance
    task automatic issue_access(input logic [31:0] addr, input logic [31:0] wdata,
                                input width_e w, input logic wr, input logic [5:0] en,
                                input logic [31:0] exp_val);
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        cpu_req.width = w;
        cpu_req.read  = !wr;
        cpu_req.write = wr;
        #1;
        // DRAM requests are held while the DRAM is busy
        while (proc_busy && en[5:4] != 2'b00) begin
            @(negedge CLK);
        end
        acc_valid = 1'b1;
        rd_pend   = !wr;
        exp_rdata = exp_val;
        exp_en    = en;
        @(negedge CLK);
        cpu_req   = '0;
        acc_valid = 1'b0;
        rd_pend   = 1'b0;
    endtask

    task automatic random_dram_access(input logic store, input logic [1:0] size);
        logic [7:0]  a;
        logic [7:0]  ai;
        logic [31:0] addr;
        logic [31:0] data;
        width_e      w;
        seed = xorshift(seed);
        a    = seed[7:0] & ~((8'd1 << size) - 8'd1);
        addr = {seed[31] ? 4'h8 : 4'h0, seed[27:8], a};
        seed = xorshift(seed);
        data = seed;
        if (store) begin
            w = width_e'({1'b0, size});
            issue_access(addr, data, w, 1'b1, 6'b010000, 32'h0);
            for (int b = 0; b < (1 << size); b++) begin
                ai = a + 8'(b);
                ref_mem[ai] = data[b * 8 +: 8];
            end
        end else begin
            w = width_e'({seed[16] && (size != 2'd2), size});
            issue_access(addr, 32'h0, w, 1'b0, 6'b100000, expected_load(a, w));
        end
    endtask

    always @(posedge CLK) begin
        rd_pend_q   <= rd_pend;
        exp_rdata_q <= exp_rdata;
        print_d1    <= print_wr;
        print_d2    <= print_d1;
        byte_d1     <= print_byte;
        byte_d2     <= byte_d1;
        fin_exp     <= !reset && (fin_exp || pwr_wr);
    end

    assert property (@(posedge CLK) disable iff (reset) rd_pend_q |-> rdata == exp_rdata_q)
        else report_mismatch("rdata", $sampled(exp_rdata_q), $sampled(rdata));
    assert property (@(posedge CLK) disable iff (reset) acc_valid |-> strobes == exp_en)
        else report_mismatch("strobes", 32'($sampled(exp_en)), 32'($sampled(strobes)));
    assert property (@(posedge CLK) disable iff (reset)
        (mmio.plic_we || mmio.clint_we || mmio.fb_we) |-> mmio.wdata == cpu_req.wdata)
        else report_mismatch("mmio.wdata", $sampled(cpu_req.wdata), $sampled(mmio.wdata));
    assert property (@(posedge CLK) disable iff (reset)
        (cpu_req.read || cpu_req.write) |-> dram_req.addr == (cpu_req.addr & ADDR_MASK))
        else report_mismatch("dram_req.addr", $sampled(cpu_req.addr) & ADDR_MASK,
                             $sampled(dram_req.addr));
    assert property (@(posedge CLK) disable iff (reset)
        (cpu_req.read || cpu_req.write) |-> {4'h0, offset} == (cpu_req.addr & ADDR_MASK))
        else report_mismatch("offset", $sampled(cpu_req.addr) & ADDR_MASK,
                             {4'h0, $sampled(offset)});
    assert property (@(posedge CLK) disable iff (reset) uart_we == print_d2)
        else report_mismatch("uart_we", 32'($sampled(print_d2)), 32'($sampled(uart_we)));
    assert property (@(posedge CLK) disable iff (reset) uart_we |-> uart_data == byte_d2)
        else report_mismatch("uart_data", 32'($sampled(byte_d2)), 32'($sampled(uart_data)));
    assert property (@(posedge CLK) disable iff (reset) finish == fin_exp)
        else report_mismatch("finish", 32'($sampled(fin_exp)), 32'($sampled(finish)));
    assert property (@(posedge CLK) disable iff (reset)
        dram_busy |-> proc_busy && !dram_req.rd_en && !dram_req.wr_en)
        else begin
            protocol_errors++;
            $display("ERROR at %0t: DRAM enable high or proc_busy low while DRAM is busy", $time);
        end

    initial begin
        repeat (N_ACCESS * 20 + 200) @(posedge CLK);
        $display("Watchdog expired after %0d cycles, the run did not complete",
                 N_ACCESS * 20 + 200);
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        logic        wr;
        logic [31:0] addr;
        logic [5:0]  en;
        logic [31:0] exp_val;
        seed            = 32'h8355_660a;
        reset           = 1'b1;
        cpu_req         = '0;
        busy_pattern    = 8'h00;
        plic_rdata      = 32'h0;
        clint_rdata     = 32'h0;
        fb_rdata        = 32'h0;
        acc_valid       = 1'b0;
        rd_pend         = 1'b0;
        exp_rdata       = 32'h0;
        exp_en          = 6'h0;
        print_wr        = 1'b0;
        print_byte      = 8'h00;
        pwr_wr          = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        // Same fill as the DRAM model
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = 8'(i) ^ 8'h5c;
        end
        repeat (5) @(negedge CLK);
        reset = 1'b0;

        // Mixed stores and loads of every width
        for (int i = 0; i < N_RAND; i++) begin
            seed = xorshift(seed);
            random_dram_access(seed[0], (seed[2:1] == 2'd3) ? 2'd2 : seed[2:1]);
        end

        // Same mix with the DRAM free in at least one cycle of eight
        for (int i = 0; i < N_BUSY; i++) begin
            seed = xorshift(seed);
            busy_pattern = (seed[7:0] | 8'h01) & 8'h7f;
            random_dram_access(seed[8], (seed[10:9] == 2'd3) ? 2'd2 : seed[10:9]);
        end
        busy_pattern = 8'h00;

        // PLIC, CLINT, framebuffer and a dropped VirtIO slot
        for (int i = 0; i < N_MMIO; i++) begin
            seed = xorshift(seed);
            plic_rdata = seed;
            seed = xorshift(seed);
            clint_rdata = seed;
            fb_rdata = ~seed ^ 32'h5a5a_0f0f;
            seed = xorshift(seed);
            wr = seed[31];
            case (seed[1:0])
                2'd0:    addr = {4'h6, seed[27:0]};
                2'd1:    addr = {4'h7, seed[27:0]};
                2'd2:    addr = {8'h45, seed[23:0]};
                default: addr = {8'h42, seed[23:0]};
            endcase
            en    = 6'b000000;
            en[3] = (seed[1:0] == 2'd0) && wr;
            en[2] = (seed[1:0] == 2'd0) && !wr;
            en[1] = (seed[1:0] == 2'd1) && wr;
            en[0] = (seed[1:0] == 2'd2) && wr;
            exp_val = (seed[1:0] == 2'd0) ? plic_rdata :
                      (seed[1:0] == 2'd1) ? clint_rdata :
                      (seed[1:0] == 2'd2) ? fb_rdata : 32'h0;
            issue_access(addr, xorshift(seed), W_SW, wr, en, exp_val);
            @(negedge CLK);
        end

        // Print command, power-off, then a print that must be ignored
        seed = xorshift(seed);
        print_byte = seed[7:0];
        print_wr = 1'b1;
        issue_access(TOHOST, {16'h0101, 8'h00, print_byte}, W_SW, 1'b1, 6'h0, 32'h0);
        print_wr = 1'b0;
        repeat (3) @(negedge CLK);
        pwr_wr = 1'b1;
        issue_access(TOHOST, 32'h0001_0000, W_SW, 1'b1, 6'h0, 32'h0);
        pwr_wr = 1'b0;
        issue_access(TOHOST, 32'h0101_0041, W_SW, 1'b1, 6'h0, 32'h0);
        repeat (4) @(negedge CLK);
        reset = 1'b1;
        repeat (2) @(negedge CLK);
        reset = 1'b0;
        repeat (3) @(negedge CLK);

        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
logic/mem_map_pkg.sv
logic/access_pkg.sv
logic/region_decoder.sv
logic/load_aligner.sv
logic/read_return_mux.sv
logic/host_command.sv
logic/mem_interconnect.sv
testbench/dram_model.sv
testbench/tb_mem_interconnect.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_mem_interconnect
FILELIST  := project.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run fails unless the pass message appears on a line of its own
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
